//--- design/rv_pkg.sv
/* rv32i core package
   widths, instruction encodings and the state types shared by the core units */
`default_nettype none

package rv_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;     // data, address or instruction
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h8000_0000;

    // opcodes the core executes, everything else retires as a no-op
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        CLASS_ALU_REG,
        CLASS_ALU_IMM,
        CLASS_LUI,
        CLASS_AUIPC,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_BRANCH,
        CLASS_NONE      // unknown opcode
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_WAIT,
        EXECUTE
    } fetch_state_e;

endpackage

`default_nettype wire

//--- design/decode_if.sv
/* decoded instruction bus
   carries register indices, immediate and ALU control from the decoder */
`default_nettype none

interface decode_if;

    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::op_class_e op_class;
    logic [2:0]        funct3;     // branch condition select

    modport producer (output rs1, rs2, rd, imm, alu_op, op_class, funct3);

    modport reg_reader (input rs1, rs2);

    modport consumer (input rd, imm, alu_op, op_class, funct3);

endinterface

`default_nettype wire

//--- design/rv_fetch.sv
/* fetch unit
   PC register, instruction fetch FSM and instruction register */
`default_nettype none

module rv_fetch (
    input  wire                clk,
    input  wire                reset,
    input  wire                imem_req_ready,
    input  wire                imem_resp_valid,
    input  wire rv_pkg::word_t imem_resp_data,
    input  wire                jump_en,
    input  wire rv_pkg::word_t jump_target,
    output logic               imem_req_valid,
    output rv_pkg::word_t      imem_addr,
    output rv_pkg::word_t      instr,
    output rv_pkg::word_t      pc,
    output logic               exec_en
);

    rv_pkg::fetch_state_e state;
    rv_pkg::fetch_state_e state_next;

    assign imem_req_valid = (state == rv_pkg::FETCH_REQ);
    assign imem_addr      = pc;      // pc only moves after execute
    assign exec_en        = (state == rv_pkg::EXECUTE);

    always_comb begin
        state_next = state;
        case (state)
            rv_pkg::FETCH_REQ:  if (imem_req_ready) state_next = rv_pkg::FETCH_WAIT;
            rv_pkg::FETCH_WAIT: if (imem_resp_valid) state_next = rv_pkg::EXECUTE;
            rv_pkg::EXECUTE:    state_next = rv_pkg::FETCH_REQ;   // always one cycle
            default:            state_next = rv_pkg::FETCH_REQ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_pkg::FETCH_REQ;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::RESET_PC;
        end else if (exec_en) begin
            pc <= jump_en ? jump_target : pc + rv_pkg::word_t'(4);
        end
    end

    // response word lands here, decoded during execute
    always_ff @(posedge clk) begin
        if (state == rv_pkg::FETCH_WAIT && imem_resp_valid) begin
            instr <= imem_resp_data;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        imem_req_valid && !imem_req_ready |=> $stable(imem_addr));

    // a response may only follow an accepted request
    a_no_early_resp: assert property (@(posedge clk) disable iff (reset)
        state == rv_pkg::FETCH_REQ |-> !imem_resp_valid);

endmodule

`default_nettype wire

//--- design/rv_decode.sv
/* instruction decoder
   splits fields, classifies the opcode, builds immediates and the ALU op */
`default_nettype none

module rv_decode (
    input wire rv_pkg::word_t instr,
    decode_if.producer        dec
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;   // selects sub and sra
    rv_pkg::op_class_e op_class;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_b;
    rv_pkg::word_t     imm_j;
    rv_pkg::word_t     imm_u;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign dec.rd       = instr[11:7];
    assign dec.rs1      = instr[19:15];
    assign dec.rs2      = instr[24:20];
    assign dec.funct3   = funct3;
    assign dec.op_class = op_class;
    assign dec.alu_op   = alu_op;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP:     op_class = rv_pkg::CLASS_ALU_REG;
            rv_pkg::OPC_OP_IMM: op_class = rv_pkg::CLASS_ALU_IMM;
            rv_pkg::OPC_LUI:    op_class = rv_pkg::CLASS_LUI;
            rv_pkg::OPC_AUIPC:  op_class = rv_pkg::CLASS_AUIPC;
            rv_pkg::OPC_JAL:    op_class = rv_pkg::CLASS_JAL;
            rv_pkg::OPC_JALR:   op_class = rv_pkg::CLASS_JALR;
            rv_pkg::OPC_BRANCH: op_class = rv_pkg::CLASS_BRANCH;
            default:            op_class = rv_pkg::CLASS_NONE;
        endcase
    end

    always_comb begin
        case (op_class)
            rv_pkg::CLASS_ALU_IMM, rv_pkg::CLASS_JALR: dec.imm = imm_i;
            rv_pkg::CLASS_BRANCH:                      dec.imm = imm_b;
            rv_pkg::CLASS_JAL:                         dec.imm = imm_j;
            rv_pkg::CLASS_LUI, rv_pkg::CLASS_AUIPC:    dec.imm = imm_u;
            default:                                   dec.imm = '0;
        endcase
    end

    // non-ALU classes keep add, execute uses it for address sums
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (op_class == rv_pkg::CLASS_ALU_REG || op_class == rv_pkg::CLASS_ALU_IMM) begin
            case (funct3)
                3'b000: begin
                    if (op_class == rv_pkg::CLASS_ALU_REG && funct7_b5) alu_op = rv_pkg::ALU_SUB;
                end
                3'b001:  alu_op = rv_pkg::ALU_SLL;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b011:  alu_op = rv_pkg::ALU_SLTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
/* integer register file
   32 words, two combinational read ports and one clocked write port */
`default_nettype none

module rv_regfile (
    input  wire                clk,
    input  wire                reset,
    decode_if.reg_reader       src,      // rs1 / rs2
    decode_if.consumer         dst,      // rd
    input  wire                exec_en,
    input  wire                wb_en,
    input  wire rv_pkg::word_t wb_data,
    output rv_pkg::word_t      rs1_data,
    output rv_pkg::word_t      rs2_data
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exec_en && wb_en && dst.rd != '0) begin   // x0 stays zero
            regs[dst.rd] <= wb_data;
        end
    end

    assign rs1_data = regs[src.rs1];
    assign rs2_data = regs[src.rs2];

    // holds across every retired write, including those aimed at rd 0
    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        (src.rs1 == '0 |-> rs1_data == '0) and (src.rs2 == '0 |-> rs2_data == '0));

endmodule

`default_nettype wire

//--- design/rv_execute.sv
/* execute unit
   operand select, ALU, branch compare, jump target and write-back value */
`default_nettype none

module rv_execute (
    decode_if.consumer         dec,
    input  wire rv_pkg::word_t pc,
    input  wire rv_pkg::word_t rs1_data,
    input  wire rv_pkg::word_t rs2_data,
    input  wire                exec_en,
    output logic               jump_en,
    output rv_pkg::word_t      jump_target,
    output logic               wb_en,
    output rv_pkg::word_t      wb_data
);

    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    rv_pkg::word_t pc_seq;       // return address for jal / jalr
    logic [4:0]    shamt;
    logic          branch_taken;

    assign pc_seq = pc + rv_pkg::word_t'(4);
    assign shamt  = alu_b[4:0];

    always_comb begin
        alu_a = rs1_data;
        alu_b = rs2_data;
        case (dec.op_class)
            rv_pkg::CLASS_ALU_IMM, rv_pkg::CLASS_JALR: alu_b = dec.imm;
            rv_pkg::CLASS_JAL, rv_pkg::CLASS_BRANCH, rv_pkg::CLASS_AUIPC: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            rv_pkg::CLASS_LUI: begin
                alu_a = '0;
                alu_b = dec.imm;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            rv_pkg::ALU_SLL:  alu_result = alu_a << shamt;
            rv_pkg::ALU_SLT:  alu_result = rv_pkg::word_t'($signed(alu_a) < $signed(alu_b));
            rv_pkg::ALU_SLTU: alu_result = rv_pkg::word_t'(alu_a < alu_b);
            rv_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            rv_pkg::ALU_SRL:  alu_result = alu_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
            rv_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            rv_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            default:          alu_result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);                    // beq
            3'b001:  branch_taken = (rs1_data != rs2_data);                    // bne
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));   // blt
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));  // bge
            3'b110:  branch_taken = (rs1_data < rs2_data);                     // bltu
            3'b111:  branch_taken = (rs1_data >= rs2_data);                    // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        wb_en       = 1'b1;
        wb_data     = alu_result;
        case (dec.op_class)
            rv_pkg::CLASS_JAL: begin
                jump_en = 1'b1;
                wb_data = pc_seq;
            end
            rv_pkg::CLASS_JALR: begin
                jump_en     = 1'b1;
                jump_target = {alu_result[rv_pkg::XLEN-1:1], 1'b0};
                wb_data     = pc_seq;
            end
            rv_pkg::CLASS_BRANCH: begin
                jump_en = branch_taken;
                wb_en   = 1'b0;
            end
            rv_pkg::CLASS_NONE: wb_en = 1'b0;   // no-op, pc just advances
            default: ;
        endcase
    end

    // sampled at the end of each execute cycle, the class comes from the fetched word
    a_class_known: assert property (@(negedge exec_en)
        exec_en |-> !$isunknown(dec.op_class));

endmodule

`default_nettype wire

//--- design/rv_core.sv
/* rv32i core top level
   one instruction at a time, fetch over valid/ready and retire reporting */
`default_nettype none

module rv_core (
    input  wire                    clk,
    input  wire                    reset,
    output logic                   imem_req_valid,
    input  wire                    imem_req_ready,
    output rv_pkg::word_t          imem_addr,
    input  wire                    imem_resp_valid,
    input  wire rv_pkg::word_t     imem_resp_data,
    output logic                   retire_valid,
    output rv_pkg::word_t          retire_pc,
    output logic                   retire_we,
    output rv_pkg::reg_addr_t      retire_rd,
    output rv_pkg::word_t          retire_data
);

    rv_pkg::word_t instr;
    rv_pkg::word_t pc;
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t rs2_data;
    rv_pkg::word_t jump_target;
    rv_pkg::word_t wb_data;
    logic          exec_en;
    logic          jump_en;
    logic          wb_en;

    decode_if dec_bus ();

    rv_fetch fetch_i (
        .clk             (clk),
        .reset           (reset),
        .imem_req_ready  (imem_req_ready),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .jump_en         (jump_en),
        .jump_target     (jump_target),
        .imem_req_valid  (imem_req_valid),
        .imem_addr       (imem_addr),
        .instr           (instr),
        .pc              (pc),
        .exec_en         (exec_en)
    );

    rv_decode decode_i (
        .instr (instr),
        .dec   (dec_bus)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .reset    (reset),
        .src      (dec_bus),
        .dst      (dec_bus),
        .exec_en  (exec_en),
        .wb_en    (wb_en),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute execute_i (
        .dec         (dec_bus),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .exec_en     (exec_en),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .wb_en       (wb_en),
        .wb_data     (wb_data)
    );

    // retire report, valid only in the execute cycle
    assign retire_valid = exec_en;
    assign retire_pc    = pc;
    assign retire_we    = wb_en;
    assign retire_rd    = dec_bus.rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

//--- verification/rv_model.svh
/* rv32i reference model
   instruction generator and architectural state for the kept instruction set */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

rv_pkg::word_t model_regs [32];
rv_pkg::word_t model_pc;

task automatic model_reset();
    model_pc = rv_pkg::RESET_PC;
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endtask

// alt picks sub for funct3 000 and sra for funct3 101
function automatic rv_pkg::word_t alu_calc(logic [2:0] f3, logic alt, rv_pkg::word_t a,
                                           rv_pkg::word_t b);
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_cond(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;   // reserved encodings fall through
    endcase
endfunction

// applies one instruction to the model state, returns the expected write-back
task automatic model_retire(input rv_pkg::word_t instr, output logic we,
                            output rv_pkg::word_t data);
    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_j;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t next_pc;
    logic [2:0]    f3;
    rs1_val = model_regs[instr[19:15]];
    rs2_val = model_regs[instr[24:20]];
    f3      = instr[14:12];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    imm_u   = {instr[31:12], 12'b0};
    we      = 1'b1;
    data    = '0;
    next_pc = model_pc + 32'd4;
    case (instr[6:0])
        rv_pkg::OPC_OP:     data = alu_calc(f3, instr[30], rs1_val, rs2_val);
        rv_pkg::OPC_OP_IMM: data = alu_calc(f3, f3 == 3'b101 && instr[30], rs1_val, imm_i);
        rv_pkg::OPC_LUI:    data = imm_u;
        rv_pkg::OPC_AUIPC:  data = model_pc + imm_u;
        rv_pkg::OPC_JAL: begin
            data    = model_pc + 32'd4;
            next_pc = model_pc + imm_j;
        end
        rv_pkg::OPC_JALR: begin
            data    = model_pc + 32'd4;
            next_pc = (rs1_val + imm_i) & ~32'd1;
        end
        rv_pkg::OPC_BRANCH: begin
            we = 1'b0;
            if (branch_cond(f3, rs1_val, rs2_val)) begin
                next_pc = model_pc + imm_b;
            end
        end
        default: we = 1'b0;   // unsupported, pc + 4 only
    endcase
    if (we && instr[11:7] != 5'd0) begin
        model_regs[instr[11:7]] = data;
    end
    model_pc = next_pc;
endtask

// small register window so results get reused, x0 included
function automatic rv_pkg::word_t random_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [6:0]  opc;
    logic        alt;
    int          pick;
    pick  = $urandom_range(9, 0);
    rd    = 5'($urandom_range(7, 0));
    rs1   = 5'($urandom_range(7, 0));
    rs2   = 5'($urandom_range(7, 0));
    f3    = 3'($urandom);
    alt   = 1'($urandom);
    imm12 = 12'($urandom);
    case (pick)
        0: begin
            case ($urandom_range(3, 0))
                0: opc = 7'b0000011;          // load
                1: opc = 7'b0100011;          // store
                2: opc = 7'b1110011;          // system
                default: opc = 7'b0001111;    // fence
            endcase
            return {25'($urandom), opc};
        end
        1, 2: return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd,
                      rv_pkg::OPC_OP};
        3, 4: begin
            if (f3 == 3'b001) begin
                imm12 = {7'b0, imm12[4:0]};
            end else if (f3 == 3'b101) begin
                imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
            end
            return {imm12, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
        end
        5: return {20'($urandom), rd, rv_pkg::OPC_LUI};
        6: return {20'($urandom), rd, rv_pkg::OPC_AUIPC};
        7: return {20'($urandom), rd, rv_pkg::OPC_JAL};
        8: return {imm12, rs1, 3'b000, rd, rv_pkg::OPC_JALR};
        default: return {7'($urandom), rs2, rs1, f3, 5'($urandom), rv_pkg::OPC_BRANCH};
    endcase
endfunction

`endif

//--- verification/rv_core_tb.sv
/* rv_core testbench
   random instruction memory responder with a retire checker against a reference model */
`default_nettype none

module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED           = 39;
    localparam int NUM_TESTS      = 400;              // retired instructions
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 12;

    logic              clk;
    logic              reset;
    logic              imem_req_valid;
    logic              imem_req_ready;
    rv_pkg::word_t     imem_addr;
    logic              imem_resp_valid;
    rv_pkg::word_t     imem_resp_data;
    logic              retire_valid;
    rv_pkg::word_t     retire_pc;
    logic              retire_we;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::word_t     retire_data;

    string test_name [6] = '{"alu", "upper_x0", "control_flow", "write_enable",
                             "fetch_protocol", "retire_order"};
    int            checks [6];
    int            errors [6];
    int            cycles;
    int            retired;
    int            resp_wait;
    int            resp_since_retire;
    int            total_checks;
    int            total_errors;
    logic          addr_held;
    logic          req_wanted;          // core should be requesting the next word
    rv_pkg::word_t held_addr;
    rv_pkg::word_t last_instr;          // word handed to the core, retired next

    `include "rv_model.svh"

    rv_core rv_core_i (
        .clk             (clk),
        .reset           (reset),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_addr       (imem_addr),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_we       (retire_we),
        .retire_rd       (retire_rd),
        .retire_data     (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input int t, input rv_pkg::word_t expected,
                               input rv_pkg::word_t actual);
        checks[t]++;
        if (expected !== actual) begin
            errors[t]++;
            $display("Fail %s: expected %h, actual %h", test_name[t], expected, actual);
        end
    endtask

    // samples the cycle that just ended, then drives the next one
    task automatic serve_fetch();
        check_value(4, req_wanted, imem_req_valid);
        if (addr_held) begin
            check_value(4, held_addr, imem_addr);
        end
        addr_held = imem_req_valid && !imem_req_ready;
        held_addr = imem_addr;
        imem_resp_valid <= 1'b0;
        imem_req_ready  <= ($urandom_range(3, 0) != 0);
        if (imem_req_valid && imem_req_ready) begin
            check_value(4, model_pc, imem_addr);
            req_wanted = 1'b0;
            resp_wait  = $urandom_range(4, 1);
        end else if (resp_wait != 0) begin
            resp_wait--;
            if (resp_wait == 0) begin
                last_instr = random_instr();
                imem_resp_valid <= 1'b1;
                imem_resp_data  <= last_instr;
                resp_since_retire++;
            end
        end
    endtask

    task automatic check_retire();
        rv_pkg::word_t exp_data;
        logic          exp_we;
        int            data_test;
        check_value(5, 1, resp_since_retire);
        resp_since_retire = 0;
        req_wanted        = 1'b1;
        check_value(2, model_pc, retire_pc);
        model_retire(last_instr, exp_we, exp_data);
        check_value(3, exp_we, retire_we);
        if (exp_we) begin
            check_value(3, last_instr[11:7], retire_rd);
            case (last_instr[6:0])
                rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: data_test = 0;
                rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: data_test = 1;
                default: data_test = 2;      // jal / jalr link value
            endcase
            check_value(data_test, exp_data, retire_data);
            if (data_test == 0 && last_instr[19:15] == 5'd0) begin
                check_value(1, exp_data, retire_data);   // operand read from x0
            end
        end
        retired++;
    endtask

    initial begin
        void'($urandom(SEED));
        reset           = 1'b1;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        addr_held       = 1'b0;
        req_wanted      = 1'b1;
        model_reset();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (retired < NUM_TESTS && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            serve_fetch();
            if (retire_valid) begin
                check_retire();
            end
        end
        if (retired < NUM_TESTS) begin
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retired, NUM_TESTS, cycles);
        end
        for (int t = 0; t < 6; t++) begin
            $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("total: %0d checks, %0d errors, %0d retired", total_checks, total_errors,
                 retired);
        if (total_errors == 0 && retired == NUM_TESTS) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+verification
design/rv_pkg.sv
design/decode_if.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_core.sv
verification/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/decode_if.sv
  - design/rv_fetch.sv
  - design/rv_decode.sv
  - design/rv_regfile.sv
  - design/rv_execute.sv
  - design/rv_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/rv_core_tb.sv
